// File: hw/audio_pkg.sv
`default_nettype none

// sample formats shared by every audio port of the mixer
package audio_pkg;

	// stereo FM sample as it leaves the chip's multiplexed DAC path
	localparam int fm_width = 9;

	// mixed output, wide enough for the 1.28 MHz stream
	localparam int out_width = 12;

	// PSG level is unsigned, only the top fm_width bits get filtered
	localparam int psg_width = 12;

	// volume is a 3-bit shift code, 7 is full scale
	localparam int vol_width = 3;

	typedef logic signed [fm_width-1:0] fm_sample_t;

	typedef logic signed [out_width-1:0] mix_sample_t;

	typedef logic [vol_width-1:0] vol_t;

endpackage

`default_nettype wire

// File: hw/filter_pkg.sv
`default_nettype none

// interpolation chain constants
package filter_pkg;

	// 54 kHz -> 321 kHz through the polyphase FIR
	localparam int interp_fir = 6;

	// 321 kHz -> 1.28 MHz through the linear stage
	localparam int interp_lin = 4;

	localparam int fir_taps_per_phase = 4;

	// Q9 coefficients, 512 is unity
	localparam int coef_width = 10;

	// clocks between two FIR outputs, the linear stage needs 2 per step
	localparam int fir_slot_cycles = 8;

	// one row per phase, tap 0 multiplies the newest sample
	// every row sums to 512 so DC passes unchanged
	localparam logic signed [coef_width-1:0] fir_coef [interp_fir*fir_taps_per_phase] = '{
		// phase 0, nearly on the newest sample
		-10, 480, 46, -4,
		-24, 440, 110, -14,
		-32, 380, 186, -22,
		// phases 3..5 mirror 2..0
		-22, 186, 380, -32,
		-14, 110, 440, -24,
		-4, 46, 480, -10
	};

	// MAC sequencing of the shared multiplier pair
	typedef enum logic [1:0] {
		fir_idle,
		fir_mac,
		fir_emit
	} fir_state_t;

endpackage

`default_nettype wire

// File: hw/fir_interp6.sv
`default_nettype none

module fir_interp6
	import audio_pkg::*, filter_pkg::*;
#(
	parameter int out_w = out_width,
	parameter int slot_cycles = fir_slot_cycles
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic sample_in,
	input wire fm_sample_t left_in,
	input wire fm_sample_t right_in,
	output logic signed [out_w-1:0] left_out,
	output logic signed [out_w-1:0] right_out,
	output logic sample_out
);

	localparam int taps = fir_taps_per_phase;
	// Q9 back to integer
	localparam int frac = coef_width - 1;
	localparam int prod_w = out_w + coef_width;
	localparam int acc_w = prod_w + $clog2(taps);
	localparam int widen = out_w - fm_width;
	localparam int sat_hi = 2**(out_w-1) - 1;
	localparam int sat_lo = -(2**(out_w-1));

	fir_state_t state;
	logic busy;
	logic [$clog2(slot_cycles)-1:0] slot_cnt;
	logic [$clog2(interp_fir)-1:0] phase;
	logic [$clog2(taps)-1:0] tap;

	// sample history, element 0 is the newest
	logic signed [out_w-1:0] hist_l [taps];
	logic signed [out_w-1:0] hist_r [taps];

	logic signed [coef_width-1:0] coef;
	logic signed [prod_w-1:0] prod_l;
	logic signed [prod_w-1:0] prod_r;
	logic signed [acc_w-1:0] acc_l;
	logic signed [acc_w-1:0] acc_r;
	logic signed [acc_w-1:0] acc_next_l;
	logic signed [acc_w-1:0] acc_next_r;

	// clamp a scaled accumulator into the output range
	function automatic logic signed [out_w-1:0] clip(input logic signed [acc_w-1:0] v);
		if (v > sat_hi)
			return out_w'(sat_hi);
		else if (v < sat_lo)
			return out_w'(sat_lo);
		else
			return v[out_w-1:0];
	endfunction

	// row = phase, column = tap
	assign coef = fir_coef[phase * taps + tap];

	// one coefficient feeds both channels in the same cycle
	assign prod_l = coef * hist_l[tap];
	assign prod_r = coef * hist_r[tap];

	// tap 0 starts a fresh sum, no separate clear cycle
	assign acc_next_l = (tap == '0) ? acc_w'(prod_l) : acc_l + prod_l;
	assign acc_next_r = (tap == '0) ? acc_w'(prod_r) : acc_r + prod_r;

	// data is already registered when emit is reached
	assign sample_out = (state == fir_emit);

	// slot timing: mac at 0..3, emit at 4, idle 5..7 of each 8-cycle slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= fir_idle;
			busy <= 1'b0;
			slot_cnt <= '0;
			phase <= '0;
			tap <= '0;
		end else if (sample_in) begin
			// new input restarts the phase sweep
			state <= fir_mac;
			busy <= 1'b1;
			slot_cnt <= '0;
			phase <= '0;
			tap <= '0;
		end else begin
			if (busy)
				slot_cnt <= (slot_cnt == slot_cycles - 1) ? '0 : slot_cnt + 1'b1;
			case (state)
				fir_mac: begin
					// tap wraps back to 0 on the last product
					tap <= tap + 1'b1;
					if (tap == taps - 1)
						state <= fir_emit;
				end
				fir_emit: begin
					state <= fir_idle;
					if (phase == interp_fir - 1)
						busy <= 1'b0;
					else
						phase <= phase + 1'b1;
				end
				default: begin
					// wait out the rest of the slot
					if (busy && slot_cnt == slot_cycles - 1)
						state <= fir_mac;
				end
			endcase
		end
	end

	// history and accumulators
	always_ff @(posedge clk) begin
		if (sample_in) begin
			// gain of 8 by widening to out_w
			hist_l[0] <= {left_in, {widen{1'b0}}};
			hist_r[0] <= {right_in, {widen{1'b0}}};
			for (int i = 1; i < taps; i++) begin
				hist_l[i] <= hist_l[i-1];
				hist_r[i] <= hist_r[i-1];
			end
		end
		if (state == fir_mac) begin
			acc_l <= acc_next_l;
			acc_r <= acc_next_r;
			// output held until the next phase completes
			if (tap == taps - 1) begin
				left_out <= clip(acc_next_l >>> frac);
				right_out <= clip(acc_next_r >>> frac);
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/linear_interp4.sv
`default_nettype none

module linear_interp4
	import audio_pkg::*, filter_pkg::*;
#(
	parameter int out_w = out_width
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic sample_in,
	input wire logic signed [out_w-1:0] left_in,
	input wire logic signed [out_w-1:0] right_in,
	input wire logic signed [out_w-1:0] left_other,
	input wire logic signed [out_w-1:0] right_other,
	output logic signed [out_w-1:0] left_out,
	output logic signed [out_w-1:0] right_out,
	output logic sample_out
);

	localparam int step_w = $clog2(interp_lin);
	localparam int sum_w = out_w + step_w + 2;
	localparam int sat_hi = 2**(out_w-1) - 1;
	localparam int sat_lo = -(2**(out_w-1));

	logic [step_w-1:0] step;
	logic toggle;
	logic [step_w-1:0] j;

	logic signed [out_w-1:0] prev_l;
	logic signed [out_w-1:0] prev_r;
	logic signed [out_w-1:0] cur_l;
	logic signed [out_w-1:0] cur_r;
	logic signed [out_w:0] diff_l;
	logic signed [out_w:0] diff_r;
	logic signed [out_w-1:0] base_l;
	logic signed [out_w-1:0] base_r;
	logic signed [out_w+step_w:0] ramp_l;
	logic signed [out_w+step_w:0] ramp_r;
	logic signed [sum_w-1:0] sum_l;
	logic signed [sum_w-1:0] sum_r;

	function automatic logic signed [out_w-1:0] clip(input logic signed [sum_w-1:0] v);
		if (v > sat_hi)
			return out_w'(sat_hi);
		else if (v < sat_lo)
			return out_w'(sat_lo);
		else
			return v[out_w-1:0];
	endfunction

	// step 1..3 pending, one output every other cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			step <= '0;
			toggle <= 1'b0;
		end else if (sample_in) begin
			step <= step_w'(1);
			toggle <= 1'b0;
		end else if (step != '0) begin
			toggle <= ~toggle;
			// wraps to 0 after the last quarter step
			if (toggle)
				step <= step + 1'b1;
		end
	end

	// difference is taken once, on arrival
	always_ff @(posedge clk) begin
		if (sample_in) begin
			prev_l <= cur_l;
			prev_r <= cur_r;
			cur_l <= left_in;
			cur_r <= right_in;
			diff_l <= left_in - cur_l;
			diff_r <= right_in - cur_r;
		end
	end

	// first output goes out with the input strobe itself
	assign sample_out = sample_in | (step != '0 && toggle);
	assign j = sample_in ? '0 : step;

	// on the strobe cycle prev is not yet updated, cur still holds it
	assign base_l = sample_in ? cur_l : prev_l;
	assign base_r = sample_in ? cur_r : prev_r;

	assign ramp_l = $signed({1'b0, j}) * diff_l;
	assign ramp_r = $signed({1'b0, j}) * diff_r;

	// quarter steps by arithmetic shift, then mix in the other source
	assign sum_l = base_l + (ramp_l >>> step_w) + left_other;
	assign sum_r = base_r + (ramp_r >>> step_w) + right_other;

	assign left_out = clip(sum_l);
	assign right_out = clip(sum_r);

endmodule

`default_nettype wire

// File: hw/audio_mixer.sv
`default_nettype none

module audio_mixer
	import audio_pkg::*, filter_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic sample,
	input wire vol_t volume,
	input wire fm_sample_t left_in,
	input wire fm_sample_t right_in,
	input wire logic [psg_width-1:0] psg,
	input wire logic enable_fm,
	input wire logic enable_psg,
	output mix_sample_t left_out,
	output mix_sample_t right_out,
	output logic sample_out
);

	localparam int out_w = out_width;
	localparam int slot_cycles = fir_slot_cycles;

	logic [2:0] rst_sync;
	logic rst_int;

	fm_sample_t fm_left;
	fm_sample_t fm_right;
	logic [psg_width-1:0] psg_gated;
	fm_sample_t psg_in;

	logic signed [out_w-1:0] fir_left;
	logic signed [out_w-1:0] fir_right;
	logic fir_strobe;
	logic signed [out_w-1:0] psg_fir;
	logic signed [out_w-1:0] psg_att;
	logic signed [out_w-1:0] mix_left;
	logic signed [out_w-1:0] mix_right;
	logic mix_strobe;

	// local reset, set at once, cleared on the third edge
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			rst_sync <= '1;
		else
			rst_sync <= {rst_sync[1:0], 1'b0};
	end

	assign rst_int = rst_sync[2];

	// source enables
	assign fm_left = enable_fm ? left_in : '0;
	assign fm_right = enable_fm ? right_in : '0;
	assign psg_gated = enable_psg ? psg : '0;

	// only the PSG MSBs fit the FIR input
	assign psg_in = psg_gated[psg_width-1 -: fm_width];

	fir_interp6 #(
		.out_w(out_w),
		.slot_cycles(slot_cycles)
	) u_fir6 (
		.clk(clk),
		.rst(rst_int),
		.sample_in(sample),
		.left_in(fm_left),
		.right_in(fm_right),
		.left_out(fir_left),
		.right_out(fir_right),
		.sample_out(fir_strobe)
	);

	// mono, right half idles on zero
	fir_interp6 #(
		.out_w(out_w),
		.slot_cycles(slot_cycles)
	) u_fir6_psg (
		.clk(clk),
		.rst(rst_int),
		.sample_in(sample),
		.left_in(psg_in),
		.right_in('0),
		.left_out(psg_fir),
		.right_out(),
		.sample_out()
	);

	// PSG sits 12 dB below FM
	assign psg_att = psg_fir >>> 2;

	linear_interp4 #(
		.out_w(out_w)
	) u_interp (
		.clk(clk),
		.rst(rst_int),
		.sample_in(fir_strobe),
		.left_in(fir_left),
		.right_in(fir_right),
		.left_other(psg_att),
		.right_other(psg_att),
		.left_out(mix_left),
		.right_out(mix_right),
		.sample_out(mix_strobe)
	);

	// volume: volume 7 passes, each step below halves
	always_ff @(posedge clk or posedge rst_int) begin
		if (rst_int) begin
			sample_out <= 1'b0;
			left_out <= '0;
			right_out <= '0;
		end else begin
			sample_out <= mix_strobe;
			if (mix_strobe) begin
				left_out <= mix_left >>> (3'd7 - volume);
				right_out <= mix_right >>> (3'd7 - volume);
			end
		end
	end

endmodule

`default_nettype wire

// File: test/mixer_properties.sv
`default_nettype none

module mixer_properties
	import audio_pkg::*, filter_pkg::*;
(
	input wire logic clk,
	input wire logic rst_int,
	input wire logic sample,
	input wire logic sample_out,
	input wire mix_sample_t left_out,
	input wire mix_sample_t right_out
);
	timeunit 1ns;
	timeprecision 1ps;

	// minimum spacing of input strobes
	localparam int period = interp_fir * fir_slot_cycles;
	// output strobes per input strobe
	localparam int n_out = interp_fir * interp_lin;
	// FIR emit after 5 cycles, then the output register
	localparam int first_out = 6;

	// held through reset and the three synchronizer edges after it
	a_reset_state: assert property (@(posedge clk)
		rst_int |-> (!sample_out && left_out == '0 && right_out == '0))
		else $error("outputs not cleared while the internal reset is active");

	// strobe on even offsets from first_out, quiet on the odd ones in between
	// last odd offset proves there is no 25th strobe
	for (genvar k = 0; k < 2 * n_out; k++) begin : g_strobe
		a_strobe: assert property (@(posedge clk) disable iff (rst_int)
			sample |-> ##(first_out + k) (sample_out == ((k % 2) == 0)))
			else $error("output strobe pattern broken %0d cycles after sample",
				first_out + k);
	end

	// producer contract, no new sample inside one full FIR sweep
	for (genvar k = 1; k < period; k++) begin : g_spacing
		a_spacing: assert property (@(posedge clk) disable iff (rst_int)
			sample |-> ##k !sample)
			else $error("sample strobe repeated after only %0d cycles", k);
	end

endmodule

bind audio_mixer mixer_properties u_properties (
	.clk(clk),
	.rst_int(rst_int),
	.sample(sample),
	.sample_out(sample_out),
	.left_out(left_out),
	.right_out(right_out)
);

`default_nettype wire

// File: test/mixer_tb.sv
`default_nettype none

module mixer_tb
	import audio_pkg::*, filter_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// tightest sample spacing the mixer accepts
	localparam int period = interp_fir * fir_slot_cycles;
	// 4 taps of history plus one period for the linear stage
	localparam int settle_periods = 5;
	localparam int n_cases = 8;
	localparam int n_periods = n_cases * settle_periods;
	localparam int sat_hi = 2**(out_width-1) - 1;
	localparam int sat_lo = -(2**(out_width-1));

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic sample = 1'b0;
	vol_t volume = '0;
	fm_sample_t left_in = '0;
	fm_sample_t right_in = '0;
	logic [psg_width-1:0] psg = '0;
	logic enable_fm = 1'b0;
	logic enable_psg = 1'b0;
	mix_sample_t left_out;
	mix_sample_t right_out;
	logic sample_out;

	logic [31:0] lfsr = 32'h7b12_878d;
	bit passed = 1'b0;
	bit fail_shown = 1'b0;

	audio_mixer dut (
		.clk(clk),
		.rst(rst),
		.sample(sample),
		.volume(volume),
		.left_in(left_in),
		.right_in(right_in),
		.psg(psg),
		.enable_fm(enable_fm),
		.enable_psg(enable_psg),
		.left_out(left_out),
		.right_out(right_out),
		.sample_out(sample_out)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	// signed value of n random bits
	function automatic int rand_fm(input int n);
		logic [31:0] v;
		v = take_bits(n);
		return v[n-1] ? int'(v) - (1 << n) : int'(v);
	endfunction

	// PSG FIR input is signed, so stay in the lower half of the level range
	function automatic int rand_psg();
		return int'(take_bits(psg_width - 1));
	endfunction

	// level a channel settles to for constant inputs
	function automatic int settled_level(input int x, input int p, input bit fm_on,
			input bit psg_on, input int vol);
		int fm_part;
		int psg_part;
		int sum;
		// widening by 3 bits gives DC gain 8, PSG then drops 12 dB
		fm_part = fm_on ? x * 8 : 0;
		psg_part = psg_on ? ((p >> 3) * 8) >>> 2 : 0;
		sum = fm_part + psg_part;
		// linear stage saturates
		if (sum > sat_hi)
			sum = sat_hi;
		else if (sum < sat_lo)
			sum = sat_lo;
		return sum >>> (7 - vol);
	endfunction

	function automatic void show_fail();
		if (!fail_shown) begin
			fail_shown = 1'b1;
			$display("Something failed");
		end
	endfunction

	task automatic abort_run(input string what);
		$display("%s", what);
		show_fail();
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input mix_sample_t got, input int expected);
		mix_sample_t exp_v;
		exp_v = mix_sample_t'(expected);
		assert (got === exp_v)
		else abort_run($sformatf("ERROR at %0t ns: %s is %0d, expected %0d",
			$time, name, got, exp_v));
	endtask

	// hold one input set for the settle time, check every strobe of the last period
	task automatic run_case(input int xl, input int xr, input int p, input bit fm_on,
			input bit psg_on, input int vol);
		int exp_l;
		int exp_r;
		int seen;
		exp_l = settled_level(xl, p, fm_on, psg_on, vol);
		exp_r = settled_level(xr, p, fm_on, psg_on, vol);
		seen = 0;
		left_in = fm_sample_t'(xl);
		right_in = fm_sample_t'(xr);
		psg = p[psg_width-1:0];
		enable_fm = fm_on;
		enable_psg = psg_on;
		volume = vol_t'(vol);
		for (int n = 0; n < settle_periods; n++) begin
			sample = 1'b1;
			@(negedge clk);
			sample = 1'b0;
			for (int c = 1; c < period; c++) begin
				@(negedge clk);
				if (n == settle_periods - 1 && sample_out) begin
					check_value("left_out", left_out, exp_l);
					check_value("right_out", right_out, exp_r);
					// at full volume the PSG cancels out of left minus right
					if (fm_on && psg_on && vol == 7)
						assert (int'(left_out) - int'(right_out) == (xl - xr) * 8)
						else abort_run($sformatf(
							"ERROR at %0t ns: left_out - right_out is %0d, expected %0d",
							$time, int'(left_out) - int'(right_out), (xl - xr) * 8));
					seen++;
				end
			end
		end
		if (seen == 0)
			abort_run("no output strobe came out during the settled period");
	endtask

	initial begin
		repeat (10) @(negedge clk);
		rst = 1'b0;
		// internal reset clears three edges later
		repeat (4) @(negedge clk);
		// DC gain at full, mid and lowest volume, PSG gated off
		run_case(rand_fm(fm_width), rand_fm(fm_width), rand_psg(), 1'b1, 1'b0, 7);
		run_case(rand_fm(fm_width), rand_fm(fm_width), rand_psg(), 1'b1, 1'b0, 4);
		run_case(rand_fm(fm_width), rand_fm(fm_width), rand_psg(), 1'b1, 1'b0, 0);
		// FM gated off, PSG alone on both channels
		run_case(rand_fm(fm_width), rand_fm(fm_width), rand_psg(), 1'b0, 1'b1, 7);
		run_case(rand_fm(fm_width), rand_fm(fm_width), rand_psg(), 1'b0, 1'b1,
			int'(take_bits(3)));
		// both sources off
		run_case(rand_fm(fm_width), rand_fm(fm_width), rand_psg(), 1'b0, 1'b0, 7);
		// both summed, 8-bit FM keeps the full-volume sum clear of saturation
		run_case(rand_fm(8), rand_fm(8), rand_psg(), 1'b1, 1'b1, 7);
		run_case(rand_fm(8), rand_fm(8), rand_psg(), 1'b1, 1'b1, int'(take_bits(3)));
		if (!fail_shown) begin
			passed = 1'b1;
			$display("Everything OK");
		end else begin
			show_fail();
		end
		$finish;
	end

	// watchdog sized from the number of sample periods
	initial begin
		#((n_periods * period + 100) * 10);
		abort_run("watchdog expired before the last case finished");
	end

	// run ended before the last case
	final begin
		if (!passed)
			show_fail();
	end

endmodule

`default_nettype wire

// File: sim.f
hw/audio_pkg.sv
hw/filter_pkg.sv
hw/fir_interp6.sv
hw/linear_interp4.sv
hw/audio_mixer.sv
test/mixer_properties.sv
test/mixer_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the mixer testbench with Verilator, verdict taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module mixer_tb -f sim.f -o mixer_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/mixer_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation FAILED"; exit 1; } \
	|| { grep -q "Everything OK" sim.log && echo "simulation passed"; }
